// ==== address_unit.f ====
source/address_unit_pkg.sv
source/io_address_decoder.sv
source/memory_bank_unit.sv
source/address_register.sv
source/address_unit.sv
testbench/tb_clock_gen.sv
testbench/address_unit_asserts.sv
testbench/address_unit_tb.sv

// ==== source/address_register.sv ====
/*
 * address register
 *   the 24-bit register loaded from the extension byte and the
 *   internal bus, its gating onto the address bus, the front
 *   panel high byte, the low byte export and the I/O decoder
 */

`timescale 1ns/1ps

module address_register
   import address_unit_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  word_t      ibus,
   input  bank_t      ext,
   input  logic       write_ar,
   input  logic       mem,
   input  logic       io,
   input  logic       fp_read_high,
   output phys_addr_t ab,
   output bank_t      fpd,
   output io_select_t devsel,
   output bank_t      ar_low
);

   // the register itself
   phys_addr_t ar;

   // high during any cycle that puts an address on the bus
   logic ab_enable;

   ////////////////////////////////////////////////////////////////////////////
   // the register
   ////////////////////////////////////////////////////////////////////////////

   // the bank unit answers in the same cycle as the load strobe, so the
   // extension byte and the bus word are captured together
   always_ff @(posedge clk) begin
      if (reset) begin
         ar <= '0;
      end else if (write_ar) begin
         ar <= {ext, ibus};
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // bus outputs
   ////////////////////////////////////////////////////////////////////////////

   // the address bus only carries the register during memory and I/O
   // cycles and reads as zero the rest of the time
   assign ab_enable = mem || io;
   assign ab = ab_enable ? ar : '0;

   // the front panel can see the whole address bus, so it only needs
   // the extension byte handed over separately
   assign fpd = fp_read_high ? ar[23:16] : '0;

   // bank unit register selection uses the low byte
   assign ar_low = ar[7:0];

   ////////////////////////////////////////////////////////////////////////////
   // device selects
   ////////////////////////////////////////////////////////////////////////////

   // decoding straight from the register rather than the gated bus lets
   // the selects settle as early as possible in the I/O cycle
   io_address_decoder u_io_address_decoder (
      .io        (io),
      .addr_high (ar[15:8]),
      .devsel    (devsel)
   );

endmodule : address_register

// ==== source/address_unit.sv ====
/*
 * address unit top level
 *   joins the address register with the memory bank unit and
 *   passes the bank unit I/O addresses down to it
 */

`timescale 1ns/1ps

module address_unit
   import address_unit_pkg::*;
#(
   parameter word_t REG_BASE    = BANK_REG_BASE,
   parameter word_t ENABLE_ADDR = BANK_ENABLE_ADDR
) (
   input  logic       clk,
   input  logic       reset,
   input  word_t      ibus,
   input  logic       write_ar,
   input  logic       mem,
   input  logic       io,
   input  logic       io_write,
   input  logic       fp_read_high,
   output phys_addr_t ab,
   output bank_t      fpd,
   output io_select_t devsel
);

   // extension byte from the bank unit to the top of the register
   bank_t ext;

   // low byte of the register, used to pick a bank unit register
   bank_t ar_low;

   // the address register also feeds its own selects back to the bank
   // unit, which lives in the system device page
   address_register u_address_register (
      .clk          (clk),
      .reset        (reset),
      .ibus         (ibus),
      .ext          (ext),
      .write_ar     (write_ar),
      .mem          (mem),
      .io           (io),
      .fp_read_high (fp_read_high),
      .ab           (ab),
      .fpd          (fpd),
      .devsel       (devsel),
      .ar_low       (ar_low)
   );

   memory_bank_unit #(
      .REG_BASE    (REG_BASE),
      .ENABLE_ADDR (ENABLE_ADDR)
   ) u_memory_bank_unit (
      .clk      (clk),
      .reset    (reset),
      .ibus     (ibus),
      .io_write (io_write),
      .sysdev   (devsel.sysdev),
      .reg_addr (ar_low),
      .ext      (ext)
   );

endmodule : address_unit

// ==== source/address_unit_pkg.sv ====
/*
 * shared definitions for the address path
 *   widths of the internal bus word, the extension byte and the
 *   physical address, the bank register index, the device-group
 *   select struct and the I/O addresses of the bank unit registers
 */

package address_unit_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths that carry a meaning
   ////////////////////////////////////////////////////////////////////////////

   // one word of the 16-bit internal bus
   typedef logic [15:0] word_t;

   // the extension byte, which becomes bits 23 to 16 of the address
   typedef logic [7:0] bank_t;

   // the full 24-bit physical address driven on the address bus
   typedef logic [23:0] phys_addr_t;

   // picks one of the eight bank registers
   // the CPU supplies it in the top three bits of the word it loads
   typedef logic [2:0] bank_index_t;

   ////////////////////////////////////////////////////////////////////////////
   // device-group selects
   ////////////////////////////////////////////////////////////////////////////

   // one field per 256-word page of the low 1K of I/O space
   // sysdev sits in bit 0 so the struct reads like the decoder outputs
   typedef struct packed {
      logic dev3xx;  // I/O 0x300 to 0x3ff
      logic dev2xx;  // I/O 0x200 to 0x2ff
      logic dev1xx;  // I/O 0x100 to 0x1ff
      logic sysdev;  // I/O 0x000 to 0x0ff
   } io_select_t;

   ////////////////////////////////////////////////////////////////////////////
   // bank unit addresses in the system page
   ////////////////////////////////////////////////////////////////////////////

   // bank register 0 lives here, registers 1 to 7 follow it
   // the base must stay aligned to eight words
   localparam word_t BANK_REG_BASE = 16'h0008;

   // writing bit 0 here turns the extension byte on or off
   localparam word_t BANK_ENABLE_ADDR = 16'h0010;

endpackage : address_unit_pkg

// ==== source/io_address_decoder.sv ====
/*
 * coarse I/O address decoder
 *   turns bits 15 to 8 of the address register into four
 *   device-group selects covering the low 1K of I/O space
 */

`timescale 1ns/1ps

module io_address_decoder
   import address_unit_pkg::*;
(
   input  logic       io,
   input  bank_t      addr_high,
   output io_select_t devsel
);

   // high when bits 15 to 10 of the address are all zero
   logic low_1k;

   // the page number inside the low 1K, taken from bits 9 and 8
   logic [1:0] page;

   ////////////////////////////////////////////////////////////////////////////
   // range check
   ////////////////////////////////////////////////////////////////////////////

   // addr_high holds address bits 15 to 8, so bits 7 to 2 of it
   // are address bits 15 to 10
   // bit 10 is checked here and nowhere else
   assign low_1k = (addr_high[7:2] == 6'd0);

   assign page = addr_high[1:0];

   ////////////////////////////////////////////////////////////////////////////
   // one-hot select
   ////////////////////////////////////////////////////////////////////////////

   // behaves like a 3-to-8 demux with two enables, of which only the
   // first four outputs are brought out
   always_comb begin
      devsel = '0;

      // outside an I/O cycle or above 0x3ff nothing is selected
      if (io && low_1k) begin
         case (page)
            2'd0: devsel.sysdev = 1'b1;
            2'd1: devsel.dev1xx = 1'b1;
            2'd2: devsel.dev2xx = 1'b1;
            default: devsel.dev3xx = 1'b1;
         endcase
      end
   end

endmodule : io_address_decoder

// ==== source/memory_bank_unit.sv ====
/*
 * memory bank unit
 *   eight bank registers and an enable flag, all written through
 *   the system device page of I/O space, and the combinational
 *   extension byte picked by the top three bits of the bus word
 */

`timescale 1ns/1ps

module memory_bank_unit
   import address_unit_pkg::*;
#(
   parameter word_t REG_BASE    = BANK_REG_BASE,
   parameter word_t ENABLE_ADDR = BANK_ENABLE_ADDR
) (
   input  logic  clk,
   input  logic  reset,
   input  word_t ibus,
   input  logic  io_write,
   input  logic  sysdev,
   input  bank_t reg_addr,
   output bank_t ext
);

   localparam int NUM_BANKS = 2 ** $bits(bank_index_t);

   // the bank registers and the flag that lets them reach the bus
   bank_t bank_regs [NUM_BANKS];
   logic  bank_enable;

   // decoded write strobes
   logic bank_reg_hit;
   logic enable_hit;

   // which register an I/O write lands in
   bank_index_t write_index;

   // which register drives the extension byte
   bank_index_t read_index;

   ////////////////////////////////////////////////////////////////////////////
   // address match inside the system page
   ////////////////////////////////////////////////////////////////////////////

   // sysdev already vouches for bits 15 to 8 being zero, so only the
   // low byte of the address register is compared here
   // the eight registers share everything but the bottom three bits
   assign bank_reg_hit = io_write && sysdev && (reg_addr[7:3] == REG_BASE[7:3]);

   assign enable_hit = io_write && sysdev && (reg_addr == ENABLE_ADDR[7:0]);

   assign write_index = reg_addr[2:0];

   ////////////////////////////////////////////////////////////////////////////
   // register file
   ////////////////////////////////////////////////////////////////////////////

   // during an I/O write the register holds the address and the bus
   // carries the data, so the byte written is the low byte of ibus
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_BANKS; i++) begin
            bank_regs[i] <= '0;
         end
         bank_enable <= 1'b0;
      end else begin
         if (bank_reg_hit) begin
            bank_regs[write_index] <= ibus[7:0];
         end
         if (enable_hit) begin
            bank_enable <= ibus[0];
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // extension byte
   ////////////////////////////////////////////////////////////////////////////

   // the bank is chosen by the word that is about to be loaded into
   // the address register, so this path has to stay combinational
   assign read_index = ibus[15:13];

   // with banking off the machine sees a plain 64K address space
   assign ext = bank_enable ? bank_regs[read_index] : '0;

endmodule : memory_bank_unit

// ==== testbench/address_unit_asserts.sv ====
/*
 * concurrent assertions for the address unit
 *   one-hot device selects, gated address bus and front panel
 *   byte, and quiet outputs right after reset
 */

`timescale 1ns/1ps

module address_unit_asserts
   import address_unit_pkg::*;
(
   input logic       clk,
   input logic       reset,
   input logic       mem,
   input logic       io,
   input logic       fp_read_high,
   input phys_addr_t ab,
   input bank_t      fpd,
   input io_select_t devsel
);

   // the decoder never selects two device groups at once
   devsel_onehot: assert property (@(posedge clk) $onehot0(devsel))
      else $error("more than one device group selected");

   // outside memory and I/O cycles the address bus reads zero
   ab_idle_zero: assert property (@(posedge clk) !(mem || io) |-> ab == '0)
      else $error("address bus not zero outside a bus cycle");

   fpd_idle_zero: assert property (@(posedge clk) !fp_read_high |-> fpd == '0)
      else $error("front panel byte not zero while not read");

   // the cleared register leaves every output at zero
   reset_clears: assert property (@(posedge clk)
      reset |=> (ab == '0 && fpd == '0 && devsel == '0))
      else $error("outputs not zero in the cycle after reset");

endmodule : address_unit_asserts

bind address_unit address_unit_asserts u_address_unit_asserts (
   .clk          (clk),
   .reset        (reset),
   .mem          (mem),
   .io           (io),
   .fp_read_high (fp_read_high),
   .ab           (ab),
   .fpd          (fpd),
   .devsel       (devsel)
);

// ==== testbench/address_unit_tb.sv ====
/*
 * testbench for the address unit
 *   random loads and I/O writes from an LCG, a reference model of
 *   the register, the banks and the enable flag, one compare task
 *   and per-test reporting with a closing count
 */

`timescale 1ns/1ps

module address_unit_tb
   import address_unit_pkg::*;
();

   localparam int RESET_TIMEOUT = 50;

   logic       clk;
   logic       reset;
   word_t      ibus;
   logic       write_ar;
   logic       mem;
   logic       io;
   logic       io_write;
   logic       fp_read_high;
   phys_addr_t ab;
   bank_t      fpd;
   io_select_t devsel;

   // reference model state
   phys_addr_t model_ar;
   bank_t      model_banks [8];
   logic       model_enable;

   int unsigned lcg_state = 96676;
   int          test_errors;
   int          tests_passed;
   int          tests_failed;

   tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(10)) u_clock_gen (.clk(clk), .reset(reset));

   address_unit UUT (
      .clk          (clk),
      .reset        (reset),
      .ibus         (ibus),
      .write_ar     (write_ar),
      .mem          (mem),
      .io           (io),
      .io_write     (io_write),
      .fp_read_high (fp_read_high),
      .ab           (ab),
      .fpd          (fpd),
      .devsel       (devsel)
   );

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   // the upper half of the LCG state has the better random bits
   function automatic word_t next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[31:16];
   endfunction

   // the bank picked by the top three bits of the loaded word
   function automatic bank_t model_ext(word_t w);
      return model_enable ? model_banks[w[15:13]] : 8'h00;
   endfunction

   // selects exist only for I/O addresses below 0x400, one per page
   function automatic io_select_t expected_devsel(logic io_v, phys_addr_t ar);
      io_select_t sel;
      sel = '0;
      if (io_v && ar[15:0] < 16'h0400) begin
         sel = io_select_t'(4'b0001 << ar[9:8]);
      end
      return sel;
   endfunction

   task automatic check_value(string name, logic [23:0] expected, logic [23:0] actual);
      if (expected !== actual) begin
         $display("FAIL %s expected %h actual %h", name, expected, actual);
         test_errors++;
      end
   endtask

   task automatic step();
      @(posedge clk);
      #2;
   endtask

   // the bank unit answers in the same cycle, so the model captures
   // the extension byte from its state before the edge
   task automatic load_ar(word_t w);
      ibus = w;
      write_ar = 1'b1;
      model_ar = {model_ext(w), w};
      step();
      write_ar = 1'b0;
   endtask

   // the register holds the I/O address and ibus carries the data
   task automatic io_write_cycle(word_t addr, word_t data, logic io_v, logic strobe);
      load_ar(addr);
      ibus = data;
      io = io_v;
      io_write = strobe;
      if (strobe && expected_devsel(io_v, model_ar).sysdev) begin
         if (model_ar[15:0] >= BANK_REG_BASE && model_ar[15:0] < BANK_REG_BASE + 16'd8) begin
            model_banks[model_ar[15:0] - BANK_REG_BASE] = data[7:0];
         end else if (model_ar[15:0] == BANK_ENABLE_ADDR) begin
            model_enable = data[0];
         end
      end
      step();
      io = 1'b0;
      io_write = 1'b0;
   endtask

   // outputs are combinational, so they are sampled 1 ns after the levels
   task automatic check_outputs(string name, logic mem_v, logic io_v, logic fp_v);
      mem = mem_v;
      io = io_v;
      fp_read_high = fp_v;
      #1;
      check_value({name, " ab"}, (mem_v || io_v) ? model_ar : 24'h0, ab);
      check_value({name, " fpd"}, fp_v ? model_ar[23:16] : 8'h00, fpd);
      check_value({name, " devsel"}, expected_devsel(io_v, model_ar), devsel);
      step();
      mem = 1'b0;
      io = 1'b0;
      fp_read_high = 1'b0;
   endtask

   task automatic finish_test(string name);
      if (test_errors == 0) begin
         $display("test %s passed", name);
         tests_passed++;
      end else begin
         $display("test %s failed with %0d errors", name, test_errors);
         tests_failed++;
      end
      test_errors = 0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic run_tests();
      word_t r;
      word_t w;
      // right after reset the register and the banks are clear
      check_outputs("reset", 1'b1, 1'b0, 1'b1);
      finish_test("reset");
      for (int i = 0; i < 20; i++) begin
         r = next_rand();
         load_ar(next_rand());
         check_outputs("plain_loads", r[0], r[1], r[2]);
      end
      finish_test("plain_loads");
      // half the words are pushed into the low 1K so every page is hit
      for (int i = 0; i < 40; i++) begin
         r = next_rand();
         w = next_rand();
         if (r[3]) begin
            w[15:10] = 6'd0;
         end
         load_ar(w);
         check_outputs("io_decode", r[0], r[1], r[2]);
      end
      finish_test("io_decode");
      for (int k = 0; k < 8; k++) begin
         io_write_cycle(BANK_REG_BASE + word_t'(k), next_rand(), 1'b1, 1'b1);
      end
      io_write_cycle(BANK_ENABLE_ADDR, 16'h0001, 1'b1, 1'b1);
      // the top three bits of each loaded word pick bank k
      for (int k = 0; k < 8; k++) begin
         r = next_rand();
         w = next_rand();
         w[15:13] = k[2:0];
         load_ar(w);
         check_outputs("bank_fill", 1'b1, r[1], r[2]);
      end
      finish_test("bank_fill");
      // wrong low byte, another device page, I/O level low, strobe low
      for (int k = 0; k < 8; k++) begin
         io_write_cycle(16'h0018 + word_t'(k), next_rand(), 1'b1, 1'b1);
         io_write_cycle(16'h0108 + word_t'(k), next_rand(), 1'b1, 1'b1);
         io_write_cycle(BANK_REG_BASE + word_t'(k), next_rand(), 1'b0, 1'b1);
         io_write_cycle(BANK_REG_BASE + word_t'(k), next_rand(), 1'b1, 1'b0);
      end
      for (int k = 0; k < 8; k++) begin
         r = next_rand();
         w = next_rand();
         w[15:13] = k[2:0];
         load_ar(w);
         check_outputs("ignored_writes", 1'b1, r[1], r[2]);
      end
      finish_test("ignored_writes");
      for (int k = 0; k < 8; k++) begin
         r = next_rand();
         w = next_rand();
         w[15:13] = k[2:0];
         load_ar(w);
         check_outputs("front_panel", r[0], r[1], 1'b1);
      end
      // bit 0 clear turns banking off, the other data bits are noise
      io_write_cycle(BANK_ENABLE_ADDR, next_rand() & 16'hfffe, 1'b1, 1'b1);
      for (int k = 0; k < 8; k++) begin
         w = next_rand();
         w[15:13] = k[2:0];
         load_ar(w);
         fp_read_high = 1'b1;
         #1;
         check_value("front_panel disabled top", 8'h00, fpd);
         check_outputs("front_panel", 1'b1, 1'b0, 1'b1);
      end
      finish_test("front_panel");
   endtask

   initial begin
      int cycles;
      ibus = '0;
      write_ar = 1'b0;
      mem = 1'b0;
      io = 1'b0;
      io_write = 1'b0;
      fp_read_high = 1'b0;
      model_ar = '0;
      model_enable = 1'b0;
      foreach (model_banks[i]) begin
         model_banks[i] = '0;
      end
      test_errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      cycles = 0;
      step();
      while (reset && cycles < RESET_TIMEOUT) begin
         step();
         cycles++;
      end
      if (reset) begin
         $display("reset still asserted after %0d cycles", RESET_TIMEOUT);
         $display("TEST FAILED");
      end else begin
         run_tests();
         $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
         if (tests_failed == 0) begin
            $display("TEST OK");
         end else begin
            $display("TEST FAILED");
         end
      end
      $finish;
   end

endmodule : address_unit_tb

// ==== testbench/tb_clock_gen.sv ====
/*
 * clock and reset source for the testbench
 *   free running clock and a reset held for a fixed number of cycles
 */

`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD       = 40,
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // reset drops right on an edge, so the DUT samples it high on
   // exactly RESET_CYCLES rising edges
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
   end

endmodule : tb_clock_gen
